// ==== src/ooo_pkg.sv ====
package ooo_pkg;

    // architectural register file, all entries general purpose
    localparam int arch_regs = 32;

    typedef logic [$clog2(arch_regs)-1:0] arch_idx_t;

    // data path word
    localparam int data_width = 32;

    typedef logic [data_width-1:0] data_t;

    // alu opcodes
    // shifts use the low five bits of rs2
    // op_mul keeps the low word of the product and is the only multi-cycle op
    typedef enum logic [3:0] {
        op_li  = 4'd0,
        op_add = 4'd1,
        op_sub = 4'd2,
        op_and = 4'd3,
        op_or  = 4'd4,
        op_xor = 4'd5,
        op_sll = 4'd6,
        op_srl = 4'd7,
        op_mul = 4'd8
    } alu_op_t;

endpackage

// ==== src/ooo_if.sv ====
// renamed instruction from rename to execute and retire
interface dispatch_if
    import ooo_pkg::*;
#(
    parameter int phy_regs  = 48,
    parameter int rob_depth = 8
) ();

    localparam int phy_w = $clog2(phy_regs);
    localparam int rob_w = $clog2(rob_depth);

    logic             valid;
    alu_op_t          op;
    data_t            imm;
    logic [phy_w-1:0] rs1_phy;
    logic [phy_w-1:0] rs2_phy;
    logic [phy_w-1:0] rd_phy;
    logic [phy_w-1:0] old_phy;
    arch_idx_t        rd_arch;
    logic [rob_w-1:0] rob_id;
    // packet consumed by execute
    logic             take;

    modport rename (
        output valid, op, imm, rs1_phy, rs2_phy, rd_phy, old_phy, rd_arch, rob_id,
        input  take
    );

    modport execute (
        input  valid, op, imm, rs1_phy, rs2_phy, rd_phy, rob_id,
        output take
    );

    modport retire (
        input valid, take, rd_arch, rd_phy, old_phy
    );

endinterface

// completed result from execute to the reorder buffer
interface result_if
    import ooo_pkg::*;
#(
    parameter int phy_regs  = 48,
    parameter int rob_depth = 8
) ();

    localparam int rob_w = $clog2(rob_depth);

    // one-cycle pulse per finished instruction
    logic             valid;
    logic [rob_w-1:0] rob_id;
    data_t            value;

    modport execute (
        output valid, rob_id, value
    );

    modport retire (
        input valid, rob_id, value
    );

endinterface

// ==== src/rename_stage.sv ====
module rename_stage
    import ooo_pkg::*;
#(
    parameter int phy_regs  = 48,
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         instr_valid,
    input  alu_op_t                      instr_op,
    input  arch_idx_t                    instr_rd,
    input  arch_idx_t                    instr_rs1,
    input  arch_idx_t                    instr_rs2,
    input  data_t                        instr_imm,
    output logic                         stall,
    dispatch_if.rename                   dispatch,
    input  logic                         free_valid,
    input  logic [$clog2(phy_regs)-1:0]  free_phy,
    input  logic [$clog2(rob_depth)-1:0] rob_tail,
    input  logic                         rob_full
);

    localparam int phy_w    = $clog2(phy_regs);
    localparam int rob_w    = $clog2(rob_depth);
    localparam int fl_depth = phy_regs - arch_regs;
    localparam int fl_ptr_w = (fl_depth > 1) ? $clog2(fl_depth) : 1;
    localparam int fl_cnt_w = $clog2(fl_depth + 1);

    // front alias table
    logic [phy_w-1:0]    rat [arch_regs];

    // circular free list
    logic [phy_w-1:0]    fl_mem [fl_depth];
    logic [fl_ptr_w-1:0] fl_head;
    logic [fl_ptr_w-1:0] fl_tail;
    logic [fl_cnt_w-1:0] fl_count;

    logic                held;
    logic                accept;

    assign held   = dispatch.valid && !dispatch.take;
    assign stall  = held || (fl_count == '0) || rob_full;
    assign accept = instr_valid && !stall;

    // identity mapping out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < arch_regs; i++) begin
                rat[i] <= phy_w'(i);
            end
        end else if (accept) begin
            rat[instr_rd] <= fl_mem[fl_head];
        end
    end

    // starts full with physical registers above the architectural range
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < fl_depth; i++) begin
                fl_mem[i] <= phy_w'(arch_regs + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= fl_cnt_w'(fl_depth);
        end else begin
            if (free_valid) begin
                fl_mem[fl_tail] <= free_phy;
                fl_tail <= (fl_tail == fl_ptr_w'(fl_depth - 1)) ? '0 : fl_tail + 1'b1;
            end
            if (accept) begin
                fl_head <= (fl_head == fl_ptr_w'(fl_depth - 1)) ? '0 : fl_head + 1'b1;
            end
            case ({free_valid, accept})
                2'b10:   fl_count <= fl_count + 1'b1;
                2'b01:   fl_count <= fl_count - 1'b1;
                default: fl_count <= fl_count;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dispatch.valid <= 1'b0;
        end else if (accept) begin
            dispatch.valid <= 1'b1;
        end else if (dispatch.take) begin
            dispatch.valid <= 1'b0;
        end
    end

    // sources are looked up before the destination is remapped
    always_ff @(posedge clk) begin
        if (accept) begin
            dispatch.op      <= instr_op;
            dispatch.imm     <= instr_imm;
            dispatch.rs1_phy <= rat[instr_rs1];
            dispatch.rs2_phy <= rat[instr_rs2];
            dispatch.rd_phy  <= fl_mem[fl_head];
            dispatch.old_phy <= rat[instr_rd];
            dispatch.rd_arch <= instr_rd;
            // a packet leaving at this edge claims the current tail
            dispatch.rob_id  <= rob_tail + rob_w'(dispatch.valid);
        end
    end

    // pointers agree with the count whenever a register is popped
    no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
        accept |-> (fl_head != fl_tail) || (fl_count == fl_cnt_w'(fl_depth)));

    // retire never returns more registers than were handed out
    no_push_when_full: assert property (@(posedge clk) disable iff (rst)
        free_valid |-> fl_count < fl_cnt_w'(fl_depth));

endmodule

// ==== src/execute_stage.sv ====
module execute_stage
    import ooo_pkg::*;
#(
    parameter int phy_regs   = 48,
    parameter int rob_depth  = 8,
    parameter int mul_cycles = 4
) (
    input  logic        clk,
    input  logic        rst,
    dispatch_if.execute dispatch,
    result_if.execute   result
);

    localparam int phy_w = $clog2(phy_regs);
    localparam int rob_w = $clog2(rob_depth);
    localparam int cnt_w = $clog2(mul_cycles);

    data_t            prf [phy_regs];

    // destination of the value held in the result register
    logic [phy_w-1:0] res_phy;

    data_t            rs1_val;
    data_t            rs2_val;
    data_t            alu_out;

    // multiplier state
    logic [cnt_w-1:0] mul_count;
    logic             mul_done;
    data_t            mul_a;
    data_t            mul_b;
    logic [phy_w-1:0] mul_phy;
    logic [rob_w-1:0] mul_rob_id;

    assign dispatch.take = dispatch.valid && (mul_count == '0);
    assign mul_done      = (mul_count == cnt_w'(1));

    // result register not yet in the prf
    assign rs1_val = (result.valid && res_phy == dispatch.rs1_phy) ? result.value
                                                                    : prf[dispatch.rs1_phy];
    assign rs2_val = (result.valid && res_phy == dispatch.rs2_phy) ? result.value
                                                                    : prf[dispatch.rs2_phy];

    always_comb begin
        case (dispatch.op)
            op_li:   alu_out = dispatch.imm;
            op_add:  alu_out = rs1_val + rs2_val;
            op_sub:  alu_out = rs1_val - rs2_val;
            op_and:  alu_out = rs1_val & rs2_val;
            op_or:   alu_out = rs1_val | rs2_val;
            op_xor:  alu_out = rs1_val ^ rs2_val;
            op_sll:  alu_out = rs1_val << rs2_val[4:0];
            op_srl:  alu_out = rs1_val >> rs2_val[4:0];
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mul_count    <= '0;
            result.valid <= 1'b0;
        end else begin
            result.valid <= 1'b0;
            if (mul_count != '0) begin
                mul_count <= mul_count - 1'b1;
                if (mul_done) begin
                    result.valid <= 1'b1;
                end
            end else if (dispatch.take) begin
                if (dispatch.op == op_mul) begin
                    mul_count <= cnt_w'(mul_cycles - 1);
                end else begin
                    result.valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch.take) begin
            if (dispatch.op == op_mul) begin
                mul_a      <= rs1_val;
                mul_b      <= rs2_val;
                mul_phy    <= dispatch.rd_phy;
                mul_rob_id <= dispatch.rob_id;
            end else begin
                res_phy       <= dispatch.rd_phy;
                result.rob_id <= dispatch.rob_id;
                result.value  <= alu_out;
            end
        end else if (mul_done) begin
            res_phy       <= mul_phy;
            result.rob_id <= mul_rob_id;
            result.value  <= mul_a * mul_b;
        end
    end

    // architectural range starts at zero, upper registers are written before use
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < arch_regs; i++) begin
                prf[i] <= '0;
            end
        end else if (result.valid) begin
            prf[res_phy] <= result.value;
        end
    end

    // packet waiting behind a running multiply stays in place
    no_take_during_mul: assert property (@(posedge clk) disable iff (rst)
        ((mul_count != '0) && dispatch.valid) |=>
            (dispatch.valid && $stable(dispatch.rob_id)));

endmodule

// ==== src/retire_stage.sv ====
module retire_stage
    import ooo_pkg::*;
#(
    parameter int phy_regs  = 48,
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    dispatch_if.retire                   dispatch,
    result_if.retire                     result,
    output logic                         free_valid,
    output logic [$clog2(phy_regs)-1:0]  free_phy,
    output logic [$clog2(rob_depth)-1:0] rob_tail,
    output logic                         rob_full,
    output logic                         retire_valid,
    output arch_idx_t                    retire_rd,
    output data_t                        retire_value
);

    localparam int phy_w = $clog2(phy_regs);
    localparam int rob_w = $clog2(rob_depth);

    // reorder buffer entries
    arch_idx_t            rob_arch [rob_depth];
    logic [phy_w-1:0]     rob_old [rob_depth];
    data_t                rob_value [rob_depth];
    logic [rob_depth-1:0] rob_done;

    logic [rob_w-1:0]     head;
    logic [rob_w:0]       count;
    logic [rob_w-1:0]     res_offset;
    logic                 alloc;
    logic                 retire;

    assign alloc      = dispatch.valid && dispatch.take;
    assign retire     = rob_done[head];
    assign res_offset = result.rob_id - head;

    // one slot kept back for the packet waiting in rename
    assign rob_full = count >= (rob_w + 1)'(rob_depth - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rob_done     <= '0;
            head         <= '0;
            rob_tail     <= '0;
            count        <= '0;
            retire_valid <= 1'b0;
            free_valid   <= 1'b0;
        end else begin
            retire_valid <= retire;
            free_valid   <= retire;
            if (alloc) begin
                rob_done[rob_tail] <= 1'b0;
                rob_tail           <= rob_tail + 1'b1;
            end
            if (result.valid) begin
                rob_done[result.rob_id] <= 1'b1;
            end
            if (retire) begin
                rob_done[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rob_arch[rob_tail] <= dispatch.rd_arch;
            rob_old[rob_tail]  <= dispatch.old_phy;
        end
        if (result.valid) begin
            rob_value[result.rob_id] <= result.value;
        end
        // head leaves, its previous mapping goes back to the free list
        if (retire) begin
            retire_rd    <= rob_arch[head];
            retire_value <= rob_value[head];
            free_phy     <= rob_old[head];
        end
    end

    result_hits_live_entry: assert property (@(posedge clk) disable iff (rst)
        result.valid |-> ((rob_w + 1)'(res_offset) < count));

    // a fresh register never aliases the mapping it replaces
    fresh_phy_differs: assert property (@(posedge clk) disable iff (rst)
        alloc |-> dispatch.rd_phy != dispatch.old_phy);

endmodule

// ==== src/ooo_core.sv ====
module ooo_core
    import ooo_pkg::*;
#(
    parameter int phy_regs   = 48,
    parameter int rob_depth  = 8,
    parameter int mul_cycles = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_valid,
    input  alu_op_t   instr_op,
    input  arch_idx_t instr_rd,
    input  arch_idx_t instr_rs1,
    input  arch_idx_t instr_rs2,
    input  data_t     instr_imm,
    output logic      stall,
    output logic      retire_valid,
    output arch_idx_t retire_rd,
    output data_t     retire_value
);

    // register recycling and rob status from retire back to rename
    logic                         free_valid;
    logic [$clog2(phy_regs)-1:0]  free_phy;
    logic [$clog2(rob_depth)-1:0] rob_tail;
    logic                         rob_full;

    dispatch_if #(.phy_regs(phy_regs), .rob_depth(rob_depth)) dispatch_bus ();
    result_if #(.phy_regs(phy_regs), .rob_depth(rob_depth)) result_bus ();

    rename_stage #(.phy_regs(phy_regs), .rob_depth(rob_depth)) rename_inst (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_op    (instr_op),
        .instr_rd    (instr_rd),
        .instr_rs1   (instr_rs1),
        .instr_rs2   (instr_rs2),
        .instr_imm   (instr_imm),
        .stall       (stall),
        .dispatch    (dispatch_bus.rename),
        .free_valid  (free_valid),
        .free_phy    (free_phy),
        .rob_tail    (rob_tail),
        .rob_full    (rob_full)
    );

    execute_stage #(
        .phy_regs   (phy_regs),
        .rob_depth  (rob_depth),
        .mul_cycles (mul_cycles)
    ) execute_inst (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch_bus.execute),
        .result   (result_bus.execute)
    );

    retire_stage #(.phy_regs(phy_regs), .rob_depth(rob_depth)) retire_inst (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (dispatch_bus.retire),
        .result       (result_bus.retire),
        .free_valid   (free_valid),
        .free_phy     (free_phy),
        .rob_tail     (rob_tail),
        .rob_full     (rob_full),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_value (retire_value)
    );

endmodule

// ==== verification/tb_ooo_core.sv ====
module tb_ooo_core
    import ooo_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int phy_regs     = 48;
    localparam int rob_depth    = 8;
    localparam int mul_cycles   = 4;
    localparam int clk_period   = 40;
    localparam int random_count = 200;
    // li burst, chain, multiply and random stream together
    localparam int total_instrs = 8 + 10 + 6 + random_count;
    localparam int watchdog_cycles = total_instrs * (mul_cycles + 4) + 200;

    logic      clk;
    logic      rst;
    logic      instr_valid;
    alu_op_t   instr_op;
    arch_idx_t instr_rd;
    arch_idx_t instr_rs1;
    arch_idx_t instr_rs2;
    data_t     instr_imm;
    logic      stall;
    logic      retire_valid;
    arch_idx_t retire_rd;
    data_t     retire_value;

    // architectural model and expected retirements in order
    data_t     model_regs [arch_regs];
    arch_idx_t exp_rd_q [$];
    data_t     exp_val_q [$];

    string     current_test;
    int        error_count;
    int        check_count;
    int        stall_cycles;

    ooo_core #(
        .phy_regs   (phy_regs),
        .rob_depth  (rob_depth),
        .mul_cycles (mul_cycles)
    ) ooo_core_inst (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr_op     (instr_op),
        .instr_rd     (instr_rd),
        .instr_rs1    (instr_rs1),
        .instr_rs2    (instr_rs2),
        .instr_imm    (instr_imm),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_value (retire_value)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("MISMATCH %s %s expected %h actual %h", current_test, what,
                     expected, actual);
            error_count++;
        end
    endtask

    function automatic data_t expected_result(input alu_op_t op, input data_t a,
                                              input data_t b, input data_t imm);
        case (op)
            op_li:   return imm;
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_mul:  return a * b;
            default: return '0;
        endcase
    endfunction

    // called 2 ns after a rising edge, returns 2 ns after the accepting edge
    task automatic issue(input alu_op_t op, input arch_idx_t rd, input arch_idx_t rs1,
                         input arch_idx_t rs2, input data_t imm);
        data_t value;
        instr_valid = 1'b1;
        instr_op    = op;
        instr_rd    = rd;
        instr_rs1   = rs1;
        instr_rs2   = rs2;
        instr_imm   = imm;
        #1;
        while (stall) begin
            stall_cycles++;
            @(posedge clk);
            #3;
        end
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
        value = expected_result(op, model_regs[rs1], model_regs[rs2], imm);
        model_regs[rd] = value;
        exp_rd_q.push_back(rd);
        exp_val_q.push_back(value);
    endtask

    task automatic finish_test(input int errors_before);
        while (exp_val_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #2;
        $display("%s finished with %0d errors", current_test, error_count - errors_before);
    endtask

    task automatic idle_after_reset();
        int errors_before;
        errors_before = error_count;
        current_test = "reset_state";
        check_value("stall", 32'd0, 32'(stall));
        check_value("retire_valid", 32'd0, 32'(retire_valid));
        // monitor flags any retirement here
        repeat (10) @(posedge clk);
        #2;
        finish_test(errors_before);
    endtask

    task automatic li_burst();
        int errors_before;
        errors_before = error_count;
        current_test = "li_burst";
        for (int i = 1; i <= 8; i++) begin
            issue(op_li, arch_idx_t'(i), '0, '0, 32'hA5C3_0000 | data_t'(i * 17));
        end
        finish_test(errors_before);
    endtask

    task automatic dependent_chain();
        int errors_before;
        errors_before = error_count;
        current_test = "dependent_chain";
        issue(op_li, 5'd10, '0, '0, 32'h1234_5678);
        issue(op_li, 5'd11, '0, '0, 32'd7);
        issue(op_add, 5'd12, 5'd10, 5'd11, '0);
        issue(op_sub, 5'd13, 5'd12, 5'd10, '0);
        issue(op_and, 5'd14, 5'd13, 5'd12, '0);
        issue(op_or, 5'd15, 5'd14, 5'd10, '0);
        issue(op_xor, 5'd16, 5'd15, 5'd12, '0);
        issue(op_sll, 5'd17, 5'd16, 5'd11, '0);
        issue(op_srl, 5'd18, 5'd17, 5'd11, '0);
        // same register renamed again while its old value is in flight
        issue(op_add, 5'd18, 5'd18, 5'd17, '0);
        finish_test(errors_before);
    endtask

    task automatic multiply_stall();
        int errors_before;
        errors_before = error_count;
        current_test = "multiply";
        stall_cycles = 0;
        issue(op_li, 5'd20, '0, '0, 32'h0001_0003);
        issue(op_li, 5'd21, '0, '0, 32'h0000_0101);
        issue(op_add, 5'd22, 5'd20, 5'd21, '0);
        issue(op_mul, 5'd23, 5'd22, 5'd21, '0);
        issue(op_add, 5'd24, 5'd23, 5'd20, '0);
        issue(op_sub, 5'd25, 5'd24, 5'd22, '0);
        check_value("stall during multiply", 32'd1, 32'(stall_cycles != 0));
        finish_test(errors_before);
    endtask

    task automatic random_stream();
        int errors_before;
        errors_before = error_count;
        current_test = "random_stream";
        for (int i = 0; i < random_count; i++) begin
            issue(alu_op_t'($urandom_range(8, 0)), arch_idx_t'($urandom_range(31, 0)),
                  arch_idx_t'($urandom_range(31, 0)), arch_idx_t'($urandom_range(31, 0)),
                  $urandom());
        end
        finish_test(errors_before);
    endtask

    always @(negedge clk) begin : retire_monitor
        arch_idx_t exp_rd;
        data_t     exp_val;
        if (!rst && retire_valid) begin
            if (exp_val_q.size() == 0) begin
                $display("unexpected retirement of r%0d while nothing was pending", retire_rd);
                error_count++;
            end else begin
                exp_rd  = exp_rd_q.pop_front();
                exp_val = exp_val_q.pop_front();
                check_value("retire_rd", 32'(exp_rd), 32'(retire_rd));
                check_value("retire_value", exp_val, retire_value);
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, %0d retirements never arrived",
                 watchdog_cycles, exp_val_q.size());
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(92543));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr_op    = op_li;
        instr_rd    = '0;
        instr_rs1   = '0;
        instr_rs2   = '0;
        instr_imm   = '0;
        error_count = 0;
        check_count = 0;
        stall_cycles = 0;
        current_test = "init";
        for (int i = 0; i < arch_regs; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        idle_after_reset();
        li_burst();
        dependent_chain();
        multiply_stall();
        random_stream();
        $display("checks %0d, errors %0d, pending %0d", check_count, error_count,
                 exp_val_q.size());
        if (error_count == 0 && exp_val_q.size() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/ooo_pkg.sv
src/ooo_if.sv
src/rename_stage.sv
src/execute_stage.sv
src/retire_stage.sv
src/ooo_core.sv
verification/tb_ooo_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_ooo_core -o sim_tb_ooo_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_ooo_core)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
